// ==== rename.f ====
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/prf.sv
rtl/rename.sv
rtl/rename_top.sv
testbench/tb_rename.sv

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pop,
    input  logic                push,
    input  rename_pkg::t_prf_id push_preg,
    output rename_pkg::t_prf_id head,
    output logic                empty
);
    import rename_pkg::*;

    localparam int DEPTH = NUM_PHYS_REGS;

    typedef logic [$clog2(DEPTH)-1:0]   t_fl_ptr;
    typedef logic [$clog2(DEPTH+1)-1:0] t_fl_cnt;

    t_prf_id fl_mem [DEPTH];
    t_fl_ptr rd_ptr;
    t_fl_ptr wr_ptr;
    t_fl_cnt count;
    logic    full;

    // depth is not a power of two so the pointers wrap by hand.
    function automatic t_fl_ptr ptr_inc(input t_fl_ptr ptr);
        ptr_inc = (ptr == t_fl_ptr'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                // the registers above the architectural range start out free.
                fl_mem[i] <= (i < NUM_FREE_REGS) ? t_prf_id'(NUM_ARCH_REGS + i) : '0;
            end
        end else if (push) begin
            fl_mem[wr_ptr] <= push_preg;
        end
    end

    ////////////////////////////////////////
    // pointers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= t_fl_ptr'(NUM_FREE_REGS);
            count  <= t_fl_cnt'(NUM_FREE_REGS);
        end else begin
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the fill level alone.
            endcase
        end
    end

    assign head  = fl_mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == t_fl_cnt'(DEPTH));

    // retirement may only return registers that were handed out.
    a_fl_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    ) else $error("free list push while full.");

endmodule

// ==== rtl/prf.sv ====
`timescale 1ns/1ps

module prf #(
    parameter int NUM_READS  = 2,
    parameter int NUM_WRITES = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [1:0]              map_rd_en,
    input  rename_pkg::t_gpr_id     map_rd_gpr [1:0],
    output rename_pkg::t_prf_id     map_psrc   [1:0],
    output logic [1:0]              map_pend,

    input  logic                    alloc_en,
    input  rename_pkg::t_gpr_id     alloc_gpr,
    output rename_pkg::t_prf_id     pdst,
    output rename_pkg::t_prf_id     pdst_old,
    output logic                    free_empty,

    input  logic                    wr_en      [NUM_WRITES-1:0],
    input  rename_pkg::t_prf_wr_pkt wr_pkt     [NUM_WRITES-1:0],

    input  logic                    rd_en      [NUM_READS-1:0],
    input  rename_pkg::t_prf_id     rd_psrc    [NUM_READS-1:0],
    output rename_pkg::t_reg_data   rd_data    [NUM_READS-1:0],

    input  logic                    free_en,
    input  rename_pkg::t_prf_id     free_preg
);
    import rename_pkg::*;

    t_prf_id                  map_q  [NUM_ARCH_REGS];
    logic [NUM_PHYS_REGS-1:0] pend_q;
    t_reg_data                data_q [NUM_PHYS_REGS];

    t_prf_id    fl_head;
    t_prf_id    map_psrc_rn0 [1:0];
    logic [1:0] map_pend_rn0;
    t_reg_data  rd_data_rd0  [NUM_READS-1:0];

    ////////////////////////////////////////
    // map and pending lookup
    ////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            map_psrc_rn0[s] = map_q[map_rd_gpr[s]];
            map_pend_rn0[s] = pend_q[map_psrc_rn0[s]];
            for (int w = 0; w < NUM_WRITES; w++) begin
                if (wr_en[w] && (wr_pkt[w].pdst == map_psrc_rn0[s])) begin
                    map_pend_rn0[s] = 1'b0;  // result arrives this cycle.
                end
            end
        end
    end

    // Data reads see a write to the same register in the same cycle.
    always_comb begin
        for (int r = 0; r < NUM_READS; r++) begin
            rd_data_rd0[r] = data_q[rd_psrc[r]];
            for (int w = 0; w < NUM_WRITES; w++) begin
                if (wr_en[w] && (wr_pkt[w].pdst == rd_psrc[r])) begin
                    rd_data_rd0[r] = wr_pkt[w].data;
                end
            end
        end
    end

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int g = 0; g < NUM_ARCH_REGS; g++) begin
                map_q[g] <= t_prf_id'(g);  // identity mapping.
            end
        end else if (alloc_en) begin
            map_q[alloc_gpr] <= fl_head;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WRITES; w++) begin
                if (wr_en[w]) begin
                    pend_q[wr_pkt[w].pdst] <= 1'b0;
                end
            end
            if (alloc_en) begin
                pend_q[fl_head] <= 1'b1;  // new register waits for its producer.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (wr_en[w]) begin
                data_q[wr_pkt[w].pdst] <= wr_pkt[w].data;
            end
        end
    end

    ////////////////////////////////////////
    // rn1 outputs
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            map_psrc[s] <= map_rd_en[s] ? map_psrc_rn0[s] : '0;
            map_pend[s] <= map_rd_en[s] & map_pend_rn0[s];
        end
        pdst     <= alloc_en ? fl_head : '0;
        pdst_old <= alloc_en ? map_q[alloc_gpr] : '0;  // mapping before this update.
        for (int r = 0; r < NUM_READS; r++) begin
            if (rd_en[r]) begin
                rd_data[r] <= rd_data_rd0[r];
            end
        end
    end

    free_list u_free_list (
        .clk       (clk),
        .arst_n    (arst_n),
        .pop       (alloc_en),
        .push      (free_en),
        .push_preg (free_preg),
        .head      (fl_head),
        .empty     (free_empty)
    );

    a_alloc_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        alloc_en |-> !free_empty
    ) else $error("allocation from an empty free list.");

    for (genvar w = 0; w < NUM_WRITES; w++) begin : g_wr_chk
        // only an allocated register that has not produced yet may be written.
        a_wr_pending: assert property (
            @(posedge clk) disable iff (!arst_n)
            wr_en[w] |-> pend_q[wr_pkt[w].pdst]
        ) else $error("write to a register that is not pending.");
    end

endmodule

// ==== rtl/rename.sv ====
`timescale 1ns/1ps

module rename #(
    parameter int NUM_READS  = 2,
    parameter int NUM_WRITES = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    valid_rn0,
    input  rename_pkg::t_uinstr     uinstr_rn0,
    output logic                    stall_rn0,

    input  logic                    wr_en   [NUM_WRITES-1:0],
    input  rename_pkg::t_prf_wr_pkt wr_pkt  [NUM_WRITES-1:0],

    input  logic                    rd_en   [NUM_READS-1:0],
    input  rename_pkg::t_prf_id     rd_psrc [NUM_READS-1:0],
    output rename_pkg::t_reg_data   rd_data [NUM_READS-1:0],

    input  logic                    free_en,
    input  rename_pkg::t_prf_id     free_preg,

    output logic                    valid_rn1,
    output rename_pkg::t_uinstr     uinstr_rn1,
    output rename_pkg::t_rename_pkt rename_rn1
);
    import rename_pkg::*;

    logic       need_pdst_rn0;
    logic       accept_rn0;
    logic       alloc_rn0;
    logic       free_empty;
    logic [1:0] map_rd_en_rn0;
    t_gpr_id    map_rd_gpr_rn0 [1:0];
    t_prf_id    map_psrc_rn1   [1:0];
    logic [1:0] map_pend_rn1;
    t_prf_id    pdst_rn1;
    t_prf_id    pdst_old_rn1;

    ////////////////////////////////////////
    // rn0
    ////////////////////////////////////////

    assign need_pdst_rn0 = valid_rn0 & (uinstr_rn0.dst.optype == OP_REG);
    assign stall_rn0     = need_pdst_rn0 & free_empty;  // upstream holds the micro-op.
    assign accept_rn0    = valid_rn0 & ~stall_rn0;
    assign alloc_rn0     = accept_rn0 & need_pdst_rn0;

    assign map_rd_en_rn0[0]  = accept_rn0 & (uinstr_rn0.src1.optype == OP_REG);
    assign map_rd_en_rn0[1]  = accept_rn0 & (uinstr_rn0.src2.optype == OP_REG);
    assign map_rd_gpr_rn0[0] = uinstr_rn0.src1.opreg;
    assign map_rd_gpr_rn0[1] = uinstr_rn0.src2.opreg;

    prf #(
        .NUM_READS  (NUM_READS),
        .NUM_WRITES (NUM_WRITES)
    ) u_prf (
        .clk        (clk),
        .arst_n     (arst_n),
        .map_rd_en  (map_rd_en_rn0),
        .map_rd_gpr (map_rd_gpr_rn0),
        .map_psrc   (map_psrc_rn1),
        .map_pend   (map_pend_rn1),
        .alloc_en   (alloc_rn0),
        .alloc_gpr  (uinstr_rn0.dst.opreg),
        .pdst       (pdst_rn1),
        .pdst_old   (pdst_old_rn1),
        .free_empty (free_empty),
        .wr_en      (wr_en),
        .wr_pkt     (wr_pkt),
        .rd_en      (rd_en),
        .rd_psrc    (rd_psrc),
        .rd_data    (rd_data),
        .free_en    (free_en),
        .free_preg  (free_preg)
    );

    ////////////////////////////////////////
    // rn1
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_rn1 <= 1'b0;
        end else begin
            valid_rn1 <= accept_rn0;  // a stalled micro-op leaves a bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rn0) begin
            uinstr_rn1 <= uinstr_rn0;
        end
    end

    assign rename_rn1 = '{psrc1:      map_psrc_rn1[0],
                          psrc1_pend: map_pend_rn1[0],
                          psrc2:      map_psrc_rn1[1],
                          psrc2_pend: map_pend_rn1[1],
                          pdst:       pdst_rn1,
                          pdst_old:   pdst_old_rn1};

    // the register file fills every field of an accepted micro-op.
    a_rn1_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_rn1 |-> !$isunknown(rename_rn1)
    ) else $error("rename result unknown at rn1.");

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    ////////////////////////////////////////
    // register file sizes
    ////////////////////////////////////////

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 48;
    localparam int NUM_FREE_REGS = NUM_PHYS_REGS - NUM_ARCH_REGS; // free after reset.

    localparam int GPR_ID_W   = $clog2(NUM_ARCH_REGS);
    localparam int PRF_ID_W   = $clog2(NUM_PHYS_REGS);
    localparam int REG_DATA_W = 32;
    localparam int TAG_W      = 8;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [GPR_ID_W-1:0]   t_gpr_id;   // architectural register number.
    typedef logic [PRF_ID_W-1:0]   t_prf_id;   // physical register number.
    typedef logic [REG_DATA_W-1:0] t_reg_data;
    typedef logic [TAG_W-1:0]      t_tag;      // follows a micro-op through the stage.

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_REG  = 2'd1,
        OP_IMM  = 2'd2
    } t_optype;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    typedef struct packed {
        t_optype optype;
        t_gpr_id opreg;
    } t_operand;

    typedef struct packed {
        t_operand src1;
        t_operand src2;
        t_operand dst;
        t_tag     tag;
    } t_uinstr;

    typedef struct packed {
        t_prf_id   pdst;
        t_reg_data data;
    } t_prf_wr_pkt;

    // Result of renaming one micro-op, valid at rn1.
    typedef struct packed {
        t_prf_id psrc1;
        logic    psrc1_pend;
        t_prf_id psrc2;
        logic    psrc2_pend;
        t_prf_id pdst;
        t_prf_id pdst_old;
    } t_rename_pkt;

endpackage

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ps

module rename_top #(
    parameter int NUM_READS  = 2,
    parameter int NUM_WRITES = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    valid_rn0,
    input  rename_pkg::t_uinstr     uinstr_rn0,
    output logic                    stall_rn0,

    input  logic                    wr_en     [NUM_WRITES-1:0],
    input  rename_pkg::t_prf_wr_pkt wr_pkt    [NUM_WRITES-1:0],

    input  logic                    rd_en     [NUM_READS-1:0],
    input  rename_pkg::t_prf_id     rd_psrc   [NUM_READS-1:0],
    output rename_pkg::t_reg_data   rd_data   [NUM_READS-1:0],

    input  logic                    free_en,
    input  rename_pkg::t_prf_id     free_preg,

    output logic                    valid_rn1,
    output rename_pkg::t_uinstr     uinstr_rn1,
    output rename_pkg::t_rename_pkt rename_rn1
);

    ////////////////////////////////////////
    // rename stage and register file
    ////////////////////////////////////////

    rename #(
        .NUM_READS  (NUM_READS),
        .NUM_WRITES (NUM_WRITES)
    ) u_rename (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid_rn0  (valid_rn0),
        .uinstr_rn0 (uinstr_rn0),
        .stall_rn0  (stall_rn0),
        .wr_en      (wr_en),
        .wr_pkt     (wr_pkt),
        .rd_en      (rd_en),
        .rd_psrc    (rd_psrc),
        .rd_data    (rd_data),
        .free_en    (free_en),
        .free_preg  (free_preg),
        .valid_rn1  (valid_rn1),
        .uinstr_rn1 (uinstr_rn1),
        .rename_rn1 (rename_rn1)  // rn1 results one cycle after acceptance.
    );

endmodule

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f rename.f --top-module tb_rename -o tb_rename \
    && ./obj_dir/tb_rename > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== testbench/tb_rename.sv ====
`timescale 1ns/1ps

module tb_rename;
    import rename_pkg::*;

    localparam int NUM_READS       = 2;
    localparam int NUM_WRITES      = 2;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;

    logic        clk;
    logic        arst_n;
    logic        valid_rn0;
    t_uinstr     uinstr_rn0;
    logic        stall_rn0;
    logic        wr_en   [NUM_WRITES-1:0];
    t_prf_wr_pkt wr_pkt  [NUM_WRITES-1:0];
    logic        rd_en   [NUM_READS-1:0];
    t_prf_id     rd_psrc [NUM_READS-1:0];
    t_reg_data   rd_data [NUM_READS-1:0];
    logic        free_en;
    t_prf_id     free_preg;
    logic        valid_rn1;
    t_uinstr     uinstr_rn1;
    t_rename_pkt rename_rn1;

    t_prf_id   map_m  [NUM_ARCH_REGS];
    logic      pend_m [NUM_PHYS_REGS];
    t_reg_data data_m [NUM_PHYS_REGS];
    t_prf_id   free_q [$];                 // same order as the free list.
    t_prf_id   old_q  [$];                 // replaced mappings that may be released.

    logic                 exp_stall = 1'b0;
    logic                 exp_valid = 1'b0;
    t_rename_pkt          exp_ren   = '0;
    t_uinstr              exp_ui    = '0;
    logic [NUM_READS-1:0] exp_rd_en = '0;
    t_reg_data            exp_rd    [NUM_READS];
    logic                 chk_valid = 1'b0;
    t_rename_pkt          chk_ren   = '0;
    t_uinstr              chk_ui    = '0;
    logic [NUM_READS-1:0] chk_rd_en = '0;
    t_reg_data            chk_rd    [NUM_READS];
    string                test_name = "reset";
    string                chk_test  = "reset";
    integer               seed      = 32'hccab761b;
    t_tag                 tag_cnt   = '0;

    rename_top #(
        .NUM_READS  (NUM_READS),
        .NUM_WRITES (NUM_WRITES)
    ) u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid_rn0  (valid_rn0),
        .uinstr_rn0 (uinstr_rn0),
        .stall_rn0  (stall_rn0),
        .wr_en      (wr_en),
        .wr_pkt     (wr_pkt),
        .rd_en      (rd_en),
        .rd_psrc    (rd_psrc),
        .rd_data    (rd_data),
        .free_en    (free_en),
        .free_preg  (free_preg),
        .valid_rn1  (valid_rn1),
        .uinstr_rn1 (uinstr_rn1),
        .rename_rn1 (rename_rn1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error.");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        abort_run($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                            test, what, expected, actual));
    endtask

    function automatic t_gpr_id rand_gpr();
        logic [31:0] r;
        r = $random(seed);
        return r[GPR_ID_W-1:0];
    endfunction

    function automatic t_uinstr make_uop(input t_optype t1, input t_gpr_id r1,
                                         input t_optype t2, input t_gpr_id r2,
                                         input t_optype td, input t_gpr_id rd);
        t_uinstr u;
        u.src1.optype = t1;
        u.src1.opreg  = r1;
        u.src2.optype = t2;
        u.src2.opreg  = r2;
        u.dst.optype  = td;
        u.dst.opreg   = rd;
        u.tag         = tag_cnt;
        tag_cnt       = tag_cnt + 1'b1;
        return u;
    endfunction

    // a result written in the rn0 cycle is no longer pending.
    function automatic logic src_pending(input t_prf_id p);
        logic pend;
        pend = pend_m[p];
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (wr_en[w] && wr_pkt[w].pdst == p) begin
                pend = 1'b0;
            end
        end
        return pend;
    endfunction

    function automatic t_reg_data read_value(input t_prf_id p);
        t_reg_data d;
        d = data_m[p];
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (wr_en[w] && wr_pkt[w].pdst == p) begin
                d = wr_pkt[w].data;
            end
        end
        return d;
    endfunction

    // drives one rn0 cycle after predicting its outcome and updating the model.
    task automatic step(input logic v, input t_uinstr ui);
        logic        need_dst;
        t_rename_pkt ren;
        ren       = '0;
        need_dst  = v && (ui.dst.optype == OP_REG);
        exp_stall = need_dst && (free_q.size() == 0);
        exp_valid = v && !exp_stall;
        if (exp_valid && ui.src1.optype == OP_REG) begin
            ren.psrc1      = map_m[ui.src1.opreg];
            ren.psrc1_pend = src_pending(ren.psrc1);
        end
        if (exp_valid && ui.src2.optype == OP_REG) begin
            ren.psrc2      = map_m[ui.src2.opreg];
            ren.psrc2_pend = src_pending(ren.psrc2);
        end
        for (int r = 0; r < NUM_READS; r++) begin
            exp_rd_en[r] = rd_en[r];
            exp_rd[r]    = read_value(rd_psrc[r]);
        end
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (wr_en[w]) begin
                pend_m[wr_pkt[w].pdst] = 1'b0;
                data_m[wr_pkt[w].pdst] = wr_pkt[w].data;
            end
        end
        if (exp_valid && need_dst) begin
            ren.pdst              = free_q.pop_front();
            ren.pdst_old          = map_m[ui.dst.opreg];
            map_m[ui.dst.opreg]   = ren.pdst;
            pend_m[ren.pdst]      = 1'b1;
            old_q.push_back(ren.pdst_old);
        end
        if (free_en) begin
            free_q.push_back(free_preg);  // behind the pop of this cycle.
        end
        exp_ren    = ren;
        exp_ui     = ui;
        valid_rn0  = v;
        uinstr_rn0 = ui;
        @(negedge clk);
        valid_rn0 = 1'b0;
        free_en   = 1'b0;
        for (int w = 0; w < NUM_WRITES; w++) begin
            wr_en[w] = 1'b0;
        end
        for (int r = 0; r < NUM_READS; r++) begin
            rd_en[r] = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    always @(posedge clk) begin
        chk_valid <= exp_valid;
        chk_ren   <= exp_ren;
        chk_ui    <= exp_ui;
        chk_rd_en <= exp_rd_en;
        chk_test  <= test_name;
        for (int r = 0; r < NUM_READS; r++) begin
            chk_rd[r] <= exp_rd[r];
        end
    end

    a_stall: assert property (@(posedge clk) disable iff (!arst_n) stall_rn0 == exp_stall)
        else report_mismatch(test_name, "stall_rn0", 32'(exp_stall), 32'($sampled(stall_rn0)));

    a_valid_rn1: assert property (@(negedge clk) disable iff (!arst_n) valid_rn1 == chk_valid)
        else report_mismatch(chk_test, "valid_rn1", 32'(chk_valid), 32'(valid_rn1));

    a_rename_rn1: assert property (@(negedge clk) disable iff (!arst_n)
        chk_valid |-> rename_rn1 == chk_ren)
        else report_mismatch(chk_test, "rename_rn1", 32'(chk_ren), 32'(rename_rn1));

    a_uinstr_rn1: assert property (@(negedge clk) disable iff (!arst_n)
        chk_valid |-> uinstr_rn1 == chk_ui)
        else report_mismatch(chk_test, "uinstr_rn1", 32'(chk_ui), 32'(uinstr_rn1));

    for (genvar r = 0; r < NUM_READS; r++) begin : g_rd_chk
        a_rd_data: assert property (@(negedge clk) disable iff (!arst_n)
            chk_rd_en[r] |-> rd_data[r] == chk_rd[r])
            else report_mismatch(chk_test, "rd_data", chk_rd[r], rd_data[r]);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished.");
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        t_gpr_id   prev;
        t_gpr_id   d;
        t_gpr_id   s;
        t_prf_id   p;
        t_uinstr   held;
        t_reg_data wdata;
        arst_n     = 1'b0;
        valid_rn0  = 1'b0;
        uinstr_rn0 = '0;
        free_en    = 1'b0;
        free_preg  = '0;
        for (int w = 0; w < NUM_WRITES; w++) begin
            wr_en[w]  = 1'b0;
            wr_pkt[w] = '0;
        end
        for (int r = 0; r < NUM_READS; r++) begin
            rd_en[r]   = 1'b0;
            rd_psrc[r] = '0;
        end
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            pend_m[i] = 1'b0;
            if (i < NUM_ARCH_REGS) begin
                map_m[i] = t_prf_id'(i);
            end else begin
                free_q.push_back(t_prf_id'(i));
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_name = "reset_mapping";
        for (int i = 0; i < NUM_ARCH_REGS / 2; i++) begin
            step(1'b1, make_uop(OP_REG, t_gpr_id'(2 * i), OP_REG, t_gpr_id'(2 * i + 1),
                                OP_NONE, '0));
            if (i % 4 == 3) begin
                step(1'b0, '0);  // a bubble keeps valid_rn1 honest.
            end
        end

        test_name = "allocation";
        prev = rand_gpr();
        for (int k = 0; k < 8; k++) begin
            d = rand_gpr();
            s = (k == 3) ? d : rand_gpr();
            step(1'b1, make_uop(OP_REG, s, OP_REG, prev, OP_REG, d));
            prev = d;
        end

        test_name = "writeback";
        p         = map_m[prev];
        wdata     = $random(seed);
        wr_en[0]  = 1'b1;
        wr_pkt[0] = '{pdst: p, data: wdata};
        step(1'b1, make_uop(OP_REG, prev, OP_NONE, '0, OP_NONE, '0));
        rd_en[0]   = 1'b1;
        rd_psrc[0] = p;
        step(1'b1, make_uop(OP_REG, prev, OP_IMM, '0, OP_NONE, '0));
        step(1'b1, make_uop(OP_NONE, '0, OP_NONE, '0, OP_REG, 5'd7));
        p          = map_m[7];
        wdata      = $random(seed);
        wr_en[1]   = 1'b1;
        wr_pkt[1]  = '{pdst: p, data: wdata};
        rd_en[1]   = 1'b1;
        rd_psrc[1] = p;
        step(1'b0, '0);
        rd_en[0]   = 1'b1;
        rd_psrc[0] = p;
        step(1'b1, make_uop(OP_REG, 5'd7, OP_REG, 5'd7, OP_NONE, '0));

        test_name = "exhaustion";
        while (free_q.size() > 0) begin
            step(1'b1, make_uop(OP_REG, rand_gpr(), OP_IMM, '0, OP_REG, rand_gpr()));
        end
        held = make_uop(OP_REG, 5'd1, OP_REG, 5'd2, OP_REG, 5'd3);
        step(1'b1, held);
        step(1'b1, held);
        step(1'b1, make_uop(OP_REG, 5'd3, OP_NONE, '0, OP_IMM, '0));

        test_name = "release_order";
        free_en   = 1'b1;
        free_preg = old_q[0];
        step(1'b1, held);  // the list is still empty at rn0.
        free_en   = 1'b1;
        free_preg = old_q[1];
        step(1'b1, held);
        free_en   = 1'b1;
        free_preg = old_q[2];
        step(1'b1, make_uop(OP_REG, 5'd3, OP_NONE, '0, OP_REG, 5'd10));
        step(1'b1, make_uop(OP_REG, 5'd10, OP_NONE, '0, OP_REG, 5'd11));
        step(1'b1, make_uop(OP_REG, 5'd11, OP_NONE, '0, OP_REG, 5'd12));
        step(1'b1, make_uop(OP_NONE, '0, OP_NONE, '0, OP_REG, 5'd13));

        step(1'b0, '0);
        step(1'b0, '0);
        @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule
